/* Makefile */
# Verilator build and run for the SRIO packet generator testbench

VERILATOR ?= verilator
TOP       ?= tb_srio_pktgen
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= RESULT: FAIL
PASS_MSG  ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/beat_assembler.sv */
/* AXIS output register, merges header and generator lanes into each beat.
   Builds the byte mask and last flag from the sequencer command. */
`timescale 1ns/10ps
`default_nettype none

module beat_assembler (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ld_hdr,
    input  logic [63:0]            hdr,
    input  pktgen_pkg::beat_cmd_t  cmd,
    input  pktgen_pkg::beat_word_u words,
    output pktgen_pkg::axis_beat_t axis
);

    import pktgen_pkg::*;

    logic [HDR_BYTES*8-1:0] hdr_q;
    logic                   valid_q;
    logic                   last_q;
    logic [BEAT_BYTES-1:0]  mask_q;
    beat_word_u             data_q;
    logic [BEAT_BYTES-1:0]  pay_mask;   // Upper nbytes bits set
    logic [BEAT_BYTES-1:0]  mask_d;
    beat_word_u             data_d;

    assign pay_mask = ~({BEAT_BYTES{1'b1}} >> cmd.nbytes);

    always_comb begin
        if (cmd.first) begin
            mask_d = {{HDR_BYTES{1'b1}}, pay_mask[BEAT_BYTES-1 -: HDR_BYTES]};
            data_d.raw = {hdr_q, words.lanes[3], words.lanes[2]};   // Header on top
        end else begin
            mask_d = pay_mask;
            data_d = words;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hdr_q   <= '0;      // Zero header until loaded
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            mask_q  <= '0;
        end else begin
            if (ld_hdr) hdr_q <= hdr;
            valid_q <= cmd.issue;               // One cycle per issued command
            last_q  <= cmd.issue & cmd.last;
            if (cmd.issue) mask_q <= mask_d;
        end
    end

    // Payload bits only
    always_ff @(posedge clk) begin
        if (cmd.issue) data_q <= data_d;
    end

    always_comb begin
        axis.valid      = valid_q;
        axis.last       = last_q;
        axis.data       = data_q;
        axis.bytes_good = mask_q;
    end

endmodule

`default_nettype wire

/* logic/pattern_gen.sv */
/* Seeded 32-bit payload word generator, constant, LFSR, increment or decrement.
   Presents four consecutive words and steps two or four of them per beat. */
`timescale 1ns/10ps
`default_nettype none

module pattern_gen (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ld_seed,
    input  logic [pktgen_pkg::WORD_W-1:0]  seed,
    input  logic                           ld_mode,
    input  pktgen_pkg::pattern_mode_e      mode,
    input  logic                           advance,  // Beat issued
    input  logic                           first,    // Header beat, two words only
    output pktgen_pkg::beat_word_u         words
);

    import pktgen_pkg::*;

    logic [WORD_W-1:0] seed_q;
    pattern_mode_e     mode_q;
    logic [WORD_W-1:0] cur_q;       // Next unused word of the sequence
    logic [WORD_W-1:0] w1;
    logic [WORD_W-1:0] w2;
    logic [WORD_W-1:0] w3;
    logic [WORD_W-1:0] w4;          // Start of the following beat

    // One step of the selected mode
    function automatic logic [WORD_W-1:0] step_word(
        input logic [WORD_W-1:0] w,
        input pattern_mode_e     m
    );
        logic [WORD_W-1:0] nxt;
        case (m)
            PAT_PRN: nxt = {w[WORD_W-2:0], ~^{w[31], w[21], w[1], w[0]}};   // x^32+x^22+x^2+x+1
            PAT_INC: nxt = w + 1'b1;
            PAT_DEC: nxt = w - 1'b1;
            default: nxt = w;                                                 // Constant
        endcase
        return nxt;
    endfunction

    // Look-ahead chain
    assign w1 = step_word(cur_q, mode_q);
    assign w2 = step_word(w1, mode_q);
    assign w3 = step_word(w2, mode_q);
    assign w4 = step_word(w3, mode_q);

    always_comb begin
        words.lanes[3] = cur_q;     // Most significant lane goes out first
        words.lanes[2] = w1;
        words.lanes[1] = w2;
        words.lanes[0] = w3;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seed_q <= '0;
            mode_q <= PAT_FIX;
            cur_q  <= '0;
        end else begin
            if (ld_seed) seed_q <= seed;
            if (ld_mode) mode_q <= mode;
            if (ld_seed || ld_mode) begin
                cur_q <= ld_seed ? seed : seed_q;     // Restart, wins over advance
            end else if (advance) begin
                cur_q <= first ? w2 : w4;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pkt_sequencer.sv */
/* Packet control FSM, counts payload bytes and issues one command per beat.
   Holds still while axis_ready is low so no beat is dropped. */
`timescale 1ns/10ps
`default_nettype none

module pkt_sequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ld_len,
    input  logic [pktgen_pkg::LEN_W-1:0]  len,
    input  logic                          send,
    input  logic                          axis_ready,
    output pktgen_pkg::beat_cmd_t         cmd,
    output logic                          rdy_bsyf
);

    import pktgen_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_PAYLOAD
    } seq_state_e;

    seq_state_e       state;
    logic [LEN_W-1:0] len_q;        // Clamped payload length
    logic [LEN_W-1:0] remain;       // Bytes left after current beat point
    logic             hdr_last;     // Whole payload fits in header beat
    logic             pay_last;     // Remaining bytes fit in one beat

    assign hdr_last = (len_q <= LEN_W'(HDR_BYTES));
    assign pay_last = (remain <= LEN_W'(BEAT_BYTES));

    // Command for this cycle
    always_comb begin
        cmd = '0;
        if (state == ST_IDLE) begin
            cmd.issue  = axis_ready & send;
            cmd.first  = 1'b1;
            cmd.last   = hdr_last;
            cmd.nbytes = hdr_last ? len_q[4:0] : 5'(HDR_BYTES);    // Up to 8 behind header
        end else begin
            cmd.issue  = axis_ready;                                // Busy, go whenever ready
            cmd.last   = pay_last;
            cmd.nbytes = pay_last ? remain[4:0] : 5'(BEAT_BYTES);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            len_q  <= '0;
            remain <= '0;
        end else begin
            if (ld_len) begin
                // Never exceed an SRIO max payload
                len_q <= (len > LEN_W'(MAX_PAYLOAD)) ? LEN_W'(MAX_PAYLOAD) : len;
            end
            if (cmd.issue) begin
                if (state == ST_IDLE) begin
                    if (!hdr_last) begin
                        state  <= ST_PAYLOAD;
                        remain <= len_q - LEN_W'(HDR_BYTES);
                    end
                end else if (pay_last) begin
                    state <= ST_IDLE;                               // Final beat issued
                end else begin
                    remain <= remain - LEN_W'(BEAT_BYTES);
                end
            end
        end
    end

    // State is registered so this is the registered idle flag
    assign rdy_bsyf = (state == ST_IDLE);

endmodule

`default_nettype wire

/* logic/pktgen_pkg.sv */
/* Shared widths, payload modes and bus structs for the SRIO packet generator.
   Every RTL block pulls its types from here. */
`default_nettype none

package pktgen_pkg;

    localparam int BEAT_BYTES  = 16;            // Bytes per AXIS beat
    localparam int HDR_BYTES   = 8;             // Header bytes riding in beat 0
    localparam int MAX_PAYLOAD = 256;           // SRIO payload ceiling
    localparam int LEN_W       = 16;
    localparam int DELAY_W     = 32;
    localparam int WORD_W      = 32;            // One generator word
    localparam int BEAT_W      = 128;           // Data bus width

    // Payload generator modes
    typedef enum logic [1:0] {
        PAT_FIX,                                // Constant seed
        PAT_PRN,                                // LFSR, XNOR feedback
        PAT_INC,
        PAT_DEC
    } pattern_mode_e;

    // Same 128 bits, seen as raw bus or as four generator lanes
    typedef union packed {
        logic [BEAT_W-1:0]           raw;
        logic [3:0][WORD_W-1:0]      lanes;    // Lane 3 is MSB
    } beat_word_u;

    // Host load strobes and values
    typedef struct packed {
        logic                        ld_hdr;
        logic [HDR_BYTES*8-1:0]      hdr;
        logic                        ld_len;
        logic [LEN_W-1:0]            len;       // Payload bytes
        logic                        ld_delay;
        logic [DELAY_W-1:0]          delay;     // Starvation delay in cycles
        logic                        ld_seed;
        logic [WORD_W-1:0]           seed;
        logic                        ld_mode;
        pattern_mode_e               mode;
    } pkt_cfg_t;

    // Sequencer to assembler, one per beat
    typedef struct packed {
        logic                        issue;     // Beat goes out next cycle
        logic                        first;     // Header beat
        logic                        last;
        logic [4:0]                  nbytes;    // Payload bytes in this beat
    } beat_cmd_t;

    // Output stream beat
    typedef struct packed {
        logic                        valid;
        logic                        last;
        beat_word_u                  data;
        logic [BEAT_BYTES-1:0]       bytes_good;    // Bit 15 covers data[127:120]
    } axis_beat_t;

endpackage

`default_nettype wire

/* logic/srio_pktgen.sv */
/* SRIO test packet generator top, host config in and one AXIS beat stream out.
   Splits the config among sequencer, pattern generator, assembler and timer. */
`timescale 1ns/10ps
`default_nettype none

module srio_pktgen (
    input  logic                  clk,
    input  logic                  reset,
    input  pktgen_pkg::pkt_cfg_t  cfg,
    input  logic                  send,             // Held until rdy_bsyf drops
    input  logic                  active,           // Enables starvation countdown
    input  logic                  axis_ready,
    output logic                  rdy_bsyf,         // High when idle
    output logic                  stream_starving,
    output pktgen_pkg::axis_beat_t axis
);

    import pktgen_pkg::*;

    beat_cmd_t  cmd;        // Per-beat command
    beat_word_u words;      // Current word plus next three

    // Byte counting and beat commands
    pkt_sequencer pkt_sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .ld_len     (cfg.ld_len),
        .len        (cfg.len),
        .send       (send),
        .axis_ready (axis_ready),
        .cmd        (cmd),
        .rdy_bsyf   (rdy_bsyf)
    );

    // Payload words, advanced by issued beats
    pattern_gen pattern_gen_i (
        .clk     (clk),
        .reset   (reset),
        .ld_seed (cfg.ld_seed),
        .seed    (cfg.seed),
        .ld_mode (cfg.ld_mode),
        .mode    (cfg.mode),
        .advance (cmd.issue),
        .first   (cmd.first),   // Header beat eats only two words
        .words   (words)
    );

    // Output register stage
    beat_assembler beat_assembler_i (
        .clk    (clk),
        .reset  (reset),
        .ld_hdr (cfg.ld_hdr),
        .hdr    (cfg.hdr),
        .cmd    (cmd),
        .words  (words),
        .axis   (axis)
    );

    starve_timer starve_timer_i (
        .clk             (clk),
        .reset           (reset),
        .ld_delay        (cfg.ld_delay),
        .delay           (cfg.delay),
        .active          (active),
        .rdy_bsyf        (rdy_bsyf),
        .stream_starving (stream_starving)
    );

endmodule

`default_nettype wire

/* logic/starve_timer.sv */
/* Idle countdown, flags stream_starving once the loaded delay has elapsed.
   Counts only while active and idle, restarts at the end of each packet. */
`timescale 1ns/10ps
`default_nettype none

module starve_timer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            ld_delay,
    input  logic [pktgen_pkg::DELAY_W-1:0]  delay,
    input  logic                            active,
    input  logic                            rdy_bsyf,
    output logic                            stream_starving
);

    import pktgen_pkg::*;

    logic [DELAY_W-1:0] delay_q;
    logic [DELAY_W-1:0] cnt;
    logic               rdy_q;          // Previous rdy_bsyf
    logic               starving_q;
    logic               reload;         // Packet just finished

    assign reload = rdy_bsyf & ~rdy_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            delay_q    <= '0;
            cnt        <= '0;
            rdy_q      <= 1'b1;
            starving_q <= 1'b0;
        end else begin
            rdy_q <= rdy_bsyf;
            if (ld_delay) begin
                delay_q <= delay;
                cnt     <= delay;                           // Start counting right away
            end else if (reload) begin
                cnt <= delay_q;
            end else if (active && rdy_bsyf && cnt > DELAY_W'(1)) begin
                cnt <= cnt - 1'b1;
            end
            // Zero delay never reaches 1
            starving_q <= active & rdy_bsyf & ~reload & ~ld_delay & (cnt == DELAY_W'(1));
        end
    end

    // Drops the same cycle a packet starts
    assign stream_starving = starving_q & rdy_bsyf;

endmodule

`default_nettype wire

/* tb.f */
logic/pktgen_pkg.sv
logic/pkt_sequencer.sv
logic/pattern_gen.sv
logic/beat_assembler.sv
logic/starve_timer.sv
logic/srio_pktgen.sv
verif/srio_pktgen_properties.sv
verif/tb_srio_pktgen.sv

/* verif/srio_pktgen_properties.sv */
/* Concurrent protocol assertions for the packet generator top.
   Bound onto every srio_pktgen instance. */
`timescale 1ns/10ps
`default_nettype none

module srio_pktgen_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   axis_ready,
    input logic                   rdy_bsyf,
    input logic                   stream_starving,
    input pktgen_pkg::axis_beat_t axis
);

    // Beat only follows a ready cycle
    valid_after_ready: assert property (@(posedge clk) disable iff (reset)
        axis.valid |-> $past(axis_ready))
        else $error("valid beat without axis_ready in the previous cycle");

    last_has_valid: assert property (@(posedge clk) disable iff (reset)
        axis.last |-> axis.valid)
        else $error("last without valid");

    starving_when_idle: assert property (@(posedge clk) disable iff (reset)
        stream_starving |-> rdy_bsyf)
        else $error("stream_starving while busy");

    // Busy ends only with the final beat
    idle_after_last: assert property (@(posedge clk) disable iff (reset)
        $rose(rdy_bsyf) |-> axis.last)
        else $error("rdy_bsyf rose without a last beat");

endmodule

bind srio_pktgen srio_pktgen_properties srio_pktgen_properties_i (
    .clk             (clk),
    .reset           (reset),
    .axis_ready      (axis_ready),
    .rdy_bsyf        (rdy_bsyf),
    .stream_starving (stream_starving),
    .axis            (axis)
);

`default_nettype wire

/* verif/tb_srio_pktgen.sv */
/* Self-checking testbench for the SRIO packet generator, with a word-sequence model.
   Runs every mode and length, back-pressure, sequence restarts and the starvation timer. */
`timescale 1ns/10ps
`default_nettype none

module tb_srio_pktgen;

    import pktgen_pkg::*;

    localparam int CLK_HALF   = 2;      // 4 ns period
    localparam int WAIT_LIMIT = 4000;   // Cycles per wait loop

    logic       clk;
    logic       reset;
    pkt_cfg_t   cfg;
    logic       send;
    logic       active;
    logic       axis_ready;
    logic       rdy_bsyf;
    logic       stream_starving;
    axis_beat_t axis;

    // Model of the generator state
    logic [WORD_W-1:0] m_word;          // Next unused word
    logic [WORD_W-1:0] m_seed;
    pattern_mode_e     m_mode;
    logic [63:0]       m_hdr;
    axis_beat_t        exp_q[$];        // Beats still to come
    int                beats_seen;
    int                lasts_seen;      // DUT beats with last set
    logic [31:0]       rng;
    logic              rand_ready;      // Random back-pressure on

    srio_pktgen srio_pktgen_i (
        .clk             (clk),
        .reset           (reset),
        .cfg             (cfg),
        .send            (send),
        .active          (active),
        .axis_ready      (axis_ready),
        .rdy_bsyf        (rdy_bsyf),
        .stream_starving (stream_starving),
        .axis            (axis)
    );

    always #CLK_HALF clk = ~clk;

    function automatic logic [15:0] lcg_next();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng[30:15];
    endfunction

    // Next word of the payload sequence for one mode
    function automatic logic [WORD_W-1:0] next_word(input logic [WORD_W-1:0] w,
                                                    input pattern_mode_e m);
        logic fb;
        fb = ~(w[31] ^ w[21] ^ w[1] ^ w[0]);     // XNOR taps 32,22,2,1
        if (m == PAT_PRN) return {w[30:0], fb};
        else if (m == PAT_INC) return w + 32'd1;
        else if (m == PAT_DEC) return w - 32'd1;
        else return w;
    endfunction

    // n ones from bit 15 down
    function automatic logic [15:0] top_mask(input int n);
        logic [15:0] m;
        m = '0;
        for (int i = 0; i < n; i++) m[15-i] = 1'b1;
        return m;
    endfunction

    task automatic abort_run(input string why);
        $display("Error at t=%0t: %s", $time, why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("Fail t=%0t: %s got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Pulse the strobes in c for one cycle, then track them in the model
    task automatic apply_cfg(input pkt_cfg_t c);
        cfg = c;
        @(posedge clk);
        #1;
        cfg = '0;
        if (c.ld_hdr) m_hdr = c.hdr;
        if (c.ld_seed) m_seed = c.seed;
        if (c.ld_mode) m_mode = c.mode;
        if (c.ld_seed || c.ld_mode) m_word = m_seed;    // Restart at seed
    endtask

    task automatic set_length(input int len);
        pkt_cfg_t c;
        c = '0;
        c.ld_len = 1'b1;
        c.len = LEN_W'(len);
        apply_cfg(c);
    endtask

    // Expected beats for one packet, consumes model words
    task automatic build_packet(input int len);
        axis_beat_t b;
        int rem;
        int nb;
        b = '0;
        b.valid = 1'b1;
        b.data.raw[127:64] = m_hdr;
        b.data.raw[63:32] = m_word;
        m_word = next_word(m_word, m_mode);
        b.data.raw[31:0] = m_word;
        m_word = next_word(m_word, m_mode);
        nb = (len < HDR_BYTES) ? len : HDR_BYTES;
        b.bytes_good = 16'hFF00 | (top_mask(nb) >> HDR_BYTES);
        b.last = (len <= HDR_BYTES);
        exp_q.push_back(b);
        rem = len - HDR_BYTES;
        while (rem > 0) begin
            for (int k = 3; k >= 0; k--) begin      // Lane 3 first out
                b.data.lanes[k] = m_word;
                m_word = next_word(m_word, m_mode);
            end
            nb = (rem < BEAT_BYTES) ? rem : BEAT_BYTES;
            b.bytes_good = top_mask(nb);
            b.last = (rem <= BEAT_BYTES);
            exp_q.push_back(b);
            rem -= BEAT_BYTES;
        end
    endtask

    task automatic send_packet(input int len);
        int n_exp;
        int start;
        int start_last;
        int t;
        logic accepted;
        n_exp = (len <= HDR_BYTES) ? 1 : 1 + (len - HDR_BYTES + BEAT_BYTES - 1) / BEAT_BYTES;
        start = beats_seen;
        start_last = lasts_seen;
        build_packet(len);
        send = 1'b1;
        accepted = 1'b0;
        t = 0;
        while (!accepted) begin
            @(negedge clk);
            accepted = send && axis_ready && rdy_bsyf;  // Taken on next edge
            @(posedge clk);
            #1;
            t++;
            if (t > WAIT_LIMIT) abort_run("send was never accepted");
        end
        send = 1'b0;
        t = 0;
        // Done once the DUT has put out its last beat and is idle again
        while (lasts_seen == start_last || !rdy_bsyf) begin
            @(posedge clk);
            #1;
            t++;
            if (t > WAIT_LIMIT) abort_run("last beat of the packet never arrived");
        end
        check("beat count", 128'(beats_seen - start), 128'(n_exp));
    endtask

    task automatic wait_starving(input int limit);
        int t;
        t = 0;
        while (!stream_starving) begin
            @(posedge clk);
            #1;
            t++;
            if (t > limit) abort_run("stream_starving did not rise within delay+3 cycles");
        end
    endtask

    // Starvation rise, hold-off during a packet, and drop with active low
    task automatic starve_test(input int d);
        pkt_cfg_t c;
        active = 1'b1;
        c = '0;
        c.ld_delay = 1'b1;
        c.delay = DELAY_W'(d);
        apply_cfg(c);
        wait_starving(d + 3);
        set_length(40);
        send_packet(40);                // Monitor flags starving while busy
        wait_starving(d + 3);           // Reloaded at end of packet
        active = 1'b0;
        @(posedge clk);
        #1;
        repeat (d + 5) begin
            check("starving with active low", 128'(stream_starving), 128'(0));
            @(posedge clk);
            #1;
        end
    endtask

    // Output monitor, one compare per valid beat
    always @(negedge clk) begin
        if (!reset) begin
            if (stream_starving && !rdy_bsyf) abort_run("stream_starving high while busy");
            if (axis.valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("beat arrived with no packet expected");
                end else begin
                    check("data", axis.data.raw, exp_q[0].data.raw);
                    check("bytes_good", 128'(axis.bytes_good), 128'(exp_q[0].bytes_good));
                    check("last", 128'(axis.last), 128'(exp_q[0].last));
                    void'(exp_q.pop_front());
                    beats_seen++;
                    if (axis.last) lasts_seen++;
                end
            end
        end
    end

    // Ready driver, random lows when enabled
    always @(posedge clk) begin
        #1;
        axis_ready = rand_ready ? ((lcg_next() % 16'd4) != 16'd0) : 1'b1;
    end

    initial begin
        int lens[6];
        int len_r;
        pkt_cfg_t c;
        lens = '{0, 5, 8, 9, 24, 256};
        clk = 1'b0;
        reset = 1'b1;
        cfg = '0;
        send = 1'b0;
        active = 1'b0;
        axis_ready = 1'b1;
        rand_ready = 1'b0;
        rng = 32'd22041;
        m_word = '0;
        m_seed = '0;
        m_mode = PAT_FIX;
        m_hdr = '0;
        beats_seen = 0;
        lasts_seen = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Reset state, then one zero-length packet from defaults
        check("rdy_bsyf after reset", 128'(rdy_bsyf), 128'(1));
        check("valid after reset", 128'(axis.valid), 128'(0));
        check("starving after reset", 128'(stream_starving), 128'(0));
        send_packet(0);

        // All modes and lengths, sequence runs on between packets
        for (int i = 0; i < 4; i++) begin
            c = '0;
            c.ld_hdr = 1'b1;
            c.hdr = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
            c.ld_seed = 1'b1;
            c.seed = {lcg_next(), lcg_next()};
            c.ld_mode = 1'b1;
            c.mode = pattern_mode_e'(i);
            apply_cfg(c);
            foreach (lens[j]) begin
                set_length(lens[j]);
                send_packet(lens[j]);
            end
            c = '0;
            c.ld_mode = 1'b1;           // Mode reload alone restarts at seed
            c.mode = pattern_mode_e'(i);
            apply_cfg(c);
            send_packet(lens[5]);
        end

        // Random back-pressure, lengths and occasional reloads
        rand_ready = 1'b1;
        for (int n = 0; n < 16; n++) begin
            if (n % 4 == 0) begin
                c = '0;
                c.ld_seed = 1'b1;
                c.seed = {lcg_next(), lcg_next()};
                c.ld_mode = 1'b1;
                c.mode = pattern_mode_e'(lcg_next() % 16'd4);
                apply_cfg(c);
            end
            len_r = int'(lcg_next() % 16'd257);
            set_length(len_r);
            send_packet(len_r);
        end
        rand_ready = 1'b0;

        starve_test(10);
        starve_test(3);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
